//--- rv32i_types.sv
`default_nettype none

package rv32i_types;

	// core-side address or data word
	typedef logic [31:0] rv32i_word;

	// one enable bit per byte of a word
	typedef logic [3:0] rv32i_mask;

endpackage : rv32i_types

`default_nettype wire

//--- cache_types.sv
`default_nettype none

package cache_types;

	// eight 32-bit words per line
	typedef logic [255:0] cache_line;

	// byte offset within a line, and word select within that offset
	localparam int offset_bits = 5;
	localparam int word_sel_bits = 3;

	// shared by both caches, icache never uses cs_write_back
	typedef enum logic [1:0] {
		cs_idle,
		cs_write_back,
		cs_fill,
		cs_respond
	} cache_state_e;

	typedef enum logic [1:0] {
		arb_idle,
		arb_serve_i,
		arb_serve_d
	} arb_state_e;

endpackage : cache_types

`default_nettype wire

//--- i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module i_cache
	import rv32i_types::*;
	import cache_types::*;
#(
	parameter int s_index = 3
)
(
	input logic clk,
	input logic arst_n,

	input logic mem_read,
	input rv32i_word mem_addr,
	output logic mem_resp,
	output rv32i_word mem_rdata,

	output logic pmem_read,
	output rv32i_word pmem_addr,
	input logic pmem_resp,
	input cache_line pmem_rdata
);

localparam int tag_bits = 32 - s_index - offset_bits;
localparam int lines = 2 ** s_index;

logic [tag_bits-1:0] tag_arr [lines];
cache_line data_arr [lines];
logic [lines-1:0] valid;

cache_state_e state, state_next;

logic [s_index-1:0] idx;
logic [tag_bits-1:0] tag;
logic [word_sel_bits-1:0] word_sel;
logic hit;

assign idx = mem_addr[offset_bits +: s_index];
assign tag = mem_addr[31 -: tag_bits];
assign word_sel = mem_addr[offset_bits-1 -: word_sel_bits];
assign hit = valid[idx] && (tag_arr[idx] == tag);

always_comb begin
	state_next = state;
	case (state)
		cs_idle: begin
			if (mem_read)
				state_next = hit ? cs_respond : cs_fill;
		end
		cs_fill: begin
			if (pmem_resp)
				state_next = cs_respond;
		end
		cs_respond: state_next = cs_idle;
		default: state_next = cs_idle;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= cs_idle;
		valid <= '0;
	end else begin
		state <= state_next;
		if (state == cs_fill && pmem_resp)
			valid[idx] <= 1'b1;
	end
end

// line and tag written together when the fill returns
always_ff @(posedge clk) begin
	if (state == cs_fill && pmem_resp) begin
		data_arr[idx] <= pmem_rdata;
		tag_arr[idx] <= tag;
	end
end

assign mem_resp = (state == cs_respond);
assign mem_rdata = data_arr[idx][32*word_sel +: 32];

assign pmem_read = (state == cs_fill);
assign pmem_addr = {mem_addr[31:offset_bits], {offset_bits{1'b0}}};

endmodule : i_cache

`default_nettype wire

//--- d_cache.sv
`timescale 1ns/1ps
`default_nettype none

module d_cache
	import rv32i_types::*;
	import cache_types::*;
#(
	parameter int s_index = 3
)
(
	input logic clk,
	input logic arst_n,

	input logic mem_read,
	input logic mem_write,
	input rv32i_mask mem_byte_enable,
	input rv32i_word mem_addr,
	input rv32i_word mem_wdata,
	output logic mem_resp,
	output rv32i_word mem_rdata,

	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_addr,
	output cache_line pmem_wdata,
	input logic pmem_resp,
	input cache_line pmem_rdata
);

localparam int tag_bits = 32 - s_index - offset_bits;
localparam int lines = 2 ** s_index;

logic [tag_bits-1:0] tag_arr [lines];
cache_line data_arr [lines];
logic [lines-1:0] valid;
logic [lines-1:0] dirty;

cache_state_e state, state_next;

logic [s_index-1:0] idx;
logic [tag_bits-1:0] tag;
logic [word_sel_bits-1:0] word_sel;
logic hit;
rv32i_word cur_word;
rv32i_word merged;

assign idx = mem_addr[offset_bits +: s_index];
assign tag = mem_addr[31 -: tag_bits];
assign word_sel = mem_addr[offset_bits-1 -: word_sel_bits];
assign hit = valid[idx] && (tag_arr[idx] == tag);
assign cur_word = data_arr[idx][32*word_sel +: 32];

// new bytes where enabled, old bytes elsewhere
always_comb begin
	for (int i = 0; i < 4; i++)
		merged[8*i +: 8] = mem_byte_enable[i] ? mem_wdata[8*i +: 8] : cur_word[8*i +: 8];
end

always_comb begin
	state_next = state;
	case (state)
		cs_idle: begin
			if (mem_read || mem_write) begin
				if (hit)
					state_next = cs_respond;
				else if (valid[idx] && dirty[idx])
					state_next = cs_write_back;
				else
					state_next = cs_fill;
			end
		end
		cs_write_back: begin
			if (pmem_resp)
				state_next = cs_fill;
		end
		cs_fill: begin
			if (pmem_resp)
				state_next = cs_respond;
		end
		cs_respond: state_next = cs_idle;
		default: state_next = cs_idle;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= cs_idle;
		valid <= '0;
		dirty <= '0;
	end else begin
		state <= state_next;
		if (state == cs_fill && pmem_resp) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= 1'b0;
		end else if (state == cs_respond && mem_write) begin
			dirty[idx] <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (state == cs_fill && pmem_resp) begin
		data_arr[idx] <= pmem_rdata;
		tag_arr[idx] <= tag;
	end else if (state == cs_respond && mem_write) begin
		data_arr[idx][32*word_sel +: 32] <= merged;
	end
end

assign mem_resp = (state == cs_respond);
assign mem_rdata = cur_word;

// victim address rebuilt from the stored tag
assign pmem_addr = (state == cs_write_back) ?
	{tag_arr[idx], idx, {offset_bits{1'b0}}} :
	{mem_addr[31:offset_bits], {offset_bits{1'b0}}};
assign pmem_read = (state == cs_fill);
assign pmem_write = (state == cs_write_back);
assign pmem_wdata = data_arr[idx];

endmodule : d_cache

`default_nettype wire

//--- l1_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module l1_arbiter
	import rv32i_types::*;
	import cache_types::*;
(
	input logic clk,
	input logic arst_n,

	// icache side
	input logic cache_read_a,
	input rv32i_word cache_addr_a,
	output logic arb_resp_a,
	output cache_line arb_rdata_a,

	// dcache side
	input logic cache_read_b,
	input logic cache_write_b,
	input rv32i_word cache_addr_b,
	input cache_line cache_wdata_b,
	output logic arb_resp_b,
	output cache_line arb_rdata_b,

	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_address,
	output cache_line pmem_wdata,
	input logic pmem_resp,
	input cache_line pmem_rdata
);

arb_state_e state, state_next;

// dcache wins a tie
always_comb begin
	state_next = state;
	case (state)
		arb_idle: begin
			if (cache_read_b || cache_write_b)
				state_next = arb_serve_d;
			else if (cache_read_a)
				state_next = arb_serve_i;
		end
		arb_serve_i, arb_serve_d: begin
			if (pmem_resp)
				state_next = arb_idle;
		end
		default: state_next = arb_idle;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		state <= arb_idle;
	else
		state <= state_next;
end

always_comb begin
	pmem_read = 1'b0;
	pmem_write = 1'b0;
	pmem_address = '0;
	case (state)
		arb_serve_i: begin
			pmem_read = cache_read_a;
			pmem_address = cache_addr_a;
		end
		arb_serve_d: begin
			pmem_read = cache_read_b;
			pmem_write = cache_write_b;
			pmem_address = cache_addr_b;
		end
		default: ;
	endcase
end

// only the dcache ever writes
assign pmem_wdata = cache_wdata_b;

assign arb_resp_a = (state == arb_serve_i) && pmem_resp;
assign arb_resp_b = (state == arb_serve_d) && pmem_resp;
assign arb_rdata_a = pmem_rdata;
assign arb_rdata_b = pmem_rdata;

endmodule : l1_arbiter

`default_nettype wire

//--- mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module mem_hierarchy
	import rv32i_types::*;
	import cache_types::*;
#(
	parameter int s_index = 3
)
(
	input logic clk,
	input logic arst_n,

	// port A, instruction fetch
	input logic read_a,
	input rv32i_word address_a,
	output logic resp_a,
	output rv32i_word rdata_a,

	// port B, data access
	input logic read_b,
	input logic write,
	input rv32i_mask wmask,
	input rv32i_word address_b,
	input rv32i_word wdata,
	output logic resp_b,
	output rv32i_word rdata_b,

	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_address,
	input cache_line pmem_rdata,
	output cache_line pmem_wdata,
	input logic pmem_resp
);

// icache to arbiter
logic cache_read_a;
rv32i_word cache_addr_a;
logic arb_resp_a;
cache_line arb_rdata_a;

// dcache to arbiter
logic cache_read_b;
logic cache_write_b;
rv32i_word cache_addr_b;
cache_line cache_wdata_b;
logic arb_resp_b;
cache_line arb_rdata_b;

i_cache #(.s_index(s_index)) icache (
	.clk,
	.arst_n,
	.mem_read(read_a),
	.mem_addr(address_a),
	.mem_resp(resp_a),
	.mem_rdata(rdata_a),
	.pmem_read(cache_read_a),
	.pmem_addr(cache_addr_a),
	.pmem_resp(arb_resp_a),
	.pmem_rdata(arb_rdata_a)
);

d_cache #(.s_index(s_index)) dcache (
	.clk,
	.arst_n,
	.mem_read(read_b),
	.mem_write(write),
	.mem_byte_enable(wmask),
	.mem_addr(address_b),
	.mem_wdata(wdata),
	.mem_resp(resp_b),
	.mem_rdata(rdata_b),
	.pmem_read(cache_read_b),
	.pmem_write(cache_write_b),
	.pmem_addr(cache_addr_b),
	.pmem_wdata(cache_wdata_b),
	.pmem_resp(arb_resp_b),
	.pmem_rdata(arb_rdata_b)
);

l1_arbiter l1_arb (
	.clk,
	.arst_n,
	.cache_read_a,
	.cache_addr_a,
	.arb_resp_a,
	.arb_rdata_a,
	.cache_read_b,
	.cache_write_b,
	.cache_addr_b,
	.cache_wdata_b,
	.arb_resp_b,
	.arb_rdata_b,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_wdata,
	.pmem_resp,
	.pmem_rdata
);

endmodule : mem_hierarchy

`default_nettype wire

//--- tb_mem_hierarchy_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hierarchy_asserts
	import rv32i_types::*;
(
	input logic clk,
	input logic arst_n,
	input logic rd,
	input logic wr,
	input rv32i_word addr,
	input logic resp,
	input logic resp_x,
	input logic resp_y
);

// request held until memory answers
property hold_until_resp;
	@(posedge clk) disable iff (!arst_n)
	((rd || wr) && !resp) |=> (rd == $past(rd)) && (wr == $past(wr)) && $stable(addr);
endproperty

rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(rd && wr))
	else $error("pmem read and write high together");

request_stable: assert property (hold_until_resp)
	else $error("pmem command or address changed before pmem_resp");

resp_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(resp_x && resp_y))
	else $error("two exclusive signals high in the same cycle");

endmodule : tb_mem_hierarchy_asserts

bind l1_arbiter tb_mem_hierarchy_asserts arb_chk (
	.clk, .arst_n, .rd(pmem_read), .wr(pmem_write), .addr(pmem_address),
	.resp(pmem_resp), .resp_x(arb_resp_a), .resp_y(arb_resp_b)
);

// core-side read and write never requested together
bind d_cache tb_mem_hierarchy_asserts dc_chk (
	.clk, .arst_n, .rd(pmem_read), .wr(pmem_write), .addr(pmem_addr),
	.resp(pmem_resp), .resp_x(mem_read), .resp_y(mem_write)
);

`default_nettype wire

//--- tb_mem_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hierarchy
	import rv32i_types::*;
	import cache_types::*;
;

localparam int timeout_cycles = 200;

logic clk;
logic arst_n;
logic read_a;
rv32i_word address_a;
logic resp_a;
rv32i_word rdata_a;
logic read_b;
logic write;
rv32i_mask wmask;
rv32i_word address_b;
rv32i_word wdata;
logic resp_b;
rv32i_word rdata_b;
logic pmem_read;
logic pmem_write;
rv32i_word pmem_address;
cache_line pmem_rdata;
cache_line pmem_wdata;
logic pmem_resp;

cache_line mem [64];
integer seed = 32'hc507_0559;
int errors;
int checks;
bit timed_out;

mem_hierarchy #(.s_index(3)) dut_i (
	.clk,
	.arst_n,
	.read_a,
	.address_a,
	.resp_a,
	.rdata_a,
	.read_b,
	.write,
	.wmask,
	.address_b,
	.wdata,
	.resp_b,
	.rdata_b,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_rdata,
	.pmem_wdata,
	.pmem_resp
);

always #20 clk = ~clk;

task automatic check_word(input string name, input rv32i_word expected, input rv32i_word actual);
	checks++;
	if (expected !== actual) begin
		errors++;
		$display("Fail %s: expected %h, actual %h", name, expected, actual);
	end else begin
		$display("ok   %s: %h", name, actual);
	end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
	checks++;
	if (expected !== actual) begin
		errors++;
		$display("Fail %s: expected %b, actual %b", name, expected, actual);
	end else begin
		$display("ok   %s: %b", name, actual);
	end
endtask

task automatic fetch_a(input string name, input rv32i_word addr, input rv32i_word expected);
	rv32i_word got;
	bit seen;
	int cycles;
	@(posedge clk);
	#2;
	read_a = 1'b1;
	address_a = addr;
	seen = 1'b0;
	cycles = 0;
	while (!seen && cycles < timeout_cycles) begin
		@(negedge clk);
		if (resp_a) begin
			seen = 1'b1;
			got = rdata_a;
		end
		cycles++;
	end
	@(posedge clk);
	#2;
	read_a = 1'b0;
	if (seen) begin
		check_word(name, expected, got);
	end else begin
		errors++;
		timed_out = 1'b1;
		$display("%s: port A gave no response within %0d cycles", name, timeout_cycles);
	end
endtask

task automatic access_b(input string name, input bit is_write, input rv32i_word addr,
		input rv32i_word data, input rv32i_mask mask, input rv32i_word expected);
	rv32i_word got;
	bit seen;
	int cycles;
	@(posedge clk);
	#2;
	read_b = !is_write;
	write = is_write;
	address_b = addr;
	wdata = data;
	wmask = mask;
	seen = 1'b0;
	cycles = 0;
	while (!seen && cycles < timeout_cycles) begin
		@(negedge clk);
		if (resp_b) begin
			seen = 1'b1;
			got = rdata_b;
		end
		cycles++;
	end
	@(posedge clk);
	#2;
	read_b = 1'b0;
	write = 1'b0;
	if (!seen) begin
		errors++;
		timed_out = 1'b1;
		$display("%s: port B gave no response within %0d cycles", name, timeout_cycles);
	end else if (is_write) begin
		// resp must be a single-cycle pulse
		@(negedge clk);
		check_flag({name, " resp pulse"}, 1'b0, resp_b);
	end else begin
		check_word(name, expected, got);
	end
endtask

// physical memory, 64 lines, random latency of 1 to 4 cycles
initial begin
	int latency;
	int line_no;
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	for (int l = 0; l < 64; l++)
		for (int w = 0; w < 8; w++)
			mem[l][32*w +: 32] = rv32i_word'(l * 32 + w * 4) ^ 32'h5a5a_0000;
	forever begin
		@(negedge clk);
		if (arst_n && (pmem_read || pmem_write)) begin
			latency = ($random(seed) & 3) + 1;
			line_no = int'(pmem_address[10:5]);
			repeat (latency - 1) @(posedge clk);
			@(posedge clk);
			#2;
			if (pmem_write)
				mem[line_no] = pmem_wdata;
			pmem_rdata = mem[line_no];
			pmem_resp = 1'b1;
			@(posedge clk);
			#2;
			pmem_resp = 1'b0;
		end
	end
end

initial begin
	int fd;
	int count;
	int op_no;
	string line;
	string name;
	string pend_name;
	logic [7:0] port_c;
	logic [7:0] kind_c;
	rv32i_word f_addr;
	rv32i_word f_data;
	rv32i_word f_exp;
	rv32i_mask f_mask;
	rv32i_word pend_addr;
	rv32i_word pend_exp;
	bit pend;
	clk = 1'b0;
	arst_n = 1'b0;
	read_a = 1'b0;
	address_a = '0;
	read_b = 1'b0;
	write = 1'b0;
	wmask = '0;
	address_b = '0;
	wdata = '0;
	errors = 0;
	checks = 0;
	timed_out = 1'b0;
	pend = 1'b0;
	op_no = 0;

	repeat (3) @(posedge clk);
	@(negedge clk);
	check_flag("reset resp_a", 1'b0, resp_a);
	check_flag("reset resp_b", 1'b0, resp_b);
	check_flag("reset pmem_read", 1'b0, pmem_read);
	check_flag("reset pmem_write", 1'b0, pmem_write);
	@(posedge clk);
	#2;
	arst_n = 1'b1;

	fd = $fopen("mem_input.txt", "r");
	if (fd == 0) begin
		errors++;
		$display("could not open mem_input.txt");
	end else begin
		while (!timed_out && !$feof(fd)) begin
			count = 0;
			if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#")
				count = $sscanf(line, "%c %c %h %h %h %h",
					port_c, kind_c, f_addr, f_data, f_mask, f_exp);
			if (count == 6) begin
				op_no++;
				name = $sformatf("op%0d %c%c %h", op_no, port_c, kind_c, f_addr);
				if (port_c == "a" && kind_c == "j") begin
					// held back, starts in the same cycle as the next port B op
					pend = 1'b1;
					pend_name = name;
					pend_addr = f_addr;
					pend_exp = f_exp;
				end else if (port_c == "a") begin
					fetch_a(name, f_addr, f_exp);
				end else if (pend) begin
					fork
						fetch_a(pend_name, pend_addr, pend_exp);
						access_b(name, kind_c == "w", f_addr, f_data, f_mask, f_exp);
					join
					pend = 1'b0;
				end else begin
					access_b(name, kind_c == "w", f_addr, f_data, f_mask, f_exp);
				end
			end
		end
		$fclose(fd);
	end
	if (op_no == 0) begin
		errors++;
		$display("no operations were read from mem_input.txt");
	end

	@(negedge clk);
	check_flag("final pmem_read idle", 1'b0, pmem_read);
	check_flag("final pmem_write idle", 1'b0, pmem_write);

	$display("%0d checks, %0d errors", checks, errors);
	if (errors == 0)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule : tb_mem_hierarchy

`default_nettype wire

//--- mem_input.txt
# port kind address wdata mask expect
# kind r read, w write, j port A read that starts with the next port B line
a r 00000040 00000000 0 5a5a0040
a r 00000044 00000000 0 5a5a0044
b r 00000100 00000000 0 5a5a0100
b w 00000104 a1b2c3d4 5 00000000
b r 00000104 00000000 0 5ab201d4
b r 00000200 00000000 0 5a5a0200
b r 00000104 00000000 0 5ab201d4
a j 00000060 00000000 0 5a5a0060
b r 00000360 00000000 0 5a5a0360
b w 00000368 deadbeef f 00000000
b r 00000368 00000000 0 deadbeef
a r 00000064 00000000 0 5a5a0064
b r 00000460 00000000 0 5a5a0460
b w 000004e0 12345678 3 00000000
b r 00000368 00000000 0 deadbeef
a r 00000500 00000000 0 5a5a0500
b r 000004e0 00000000 0 5a5a5678

//--- filelist.f
rv32i_types.sv
cache_types.sv
i_cache.sv
d_cache.sv
l1_arbiter.sv
mem_hierarchy.sv
tb_mem_hierarchy_asserts.sv
tb_mem_hierarchy.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_hierarchy -f filelist.f -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
	exit 0
fi
exit 1
